//--- Makefile
VERILATOR ?= verilator
TOP       := hl2link_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- logic/hl2link.sv
`timescale 1ns/10ps
`default_nettype none

module hl2link (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic                     [1:0] linkrx,
  output logic                          [1:0] linktx,
  input  wire logic                           master_sel,
  input  wire logic                           cl1on_ack,
  output logic                                cl1on_rqst,
  output logic                                running,
  output logic                                rst_ack,
  input  wire logic                           send_tvalid,
  input  wire logic [hl2link_pkg::word_w-1:0] send_tdata,
  input  wire hl2link_pkg::word_kind_e        send_tuser,
  output logic                                send_tready,
  output logic                                send_tdone,
  output logic      [hl2link_pkg::word_w-1:0] recv_tdata,
  output hl2link_pkg::word_kind_e             recv_tuser,
  output logic                                recv_tdone
);

  logic [1:0] link_sync;
  logic [1:0] link_stable;
  logic [1:0] train_sym;

  link_rx_filter u_filter (
    .clk        (clk),
    .rst_n      (rst_n),
    .linkrx     (linkrx),
    .link_sync  (link_sync),
    .link_stable(link_stable)
  );

  link_trainer u_trainer (
    .clk        (clk),
    .rst_n      (rst_n),
    .master_sel (master_sel),
    .link_stable(link_stable),
    .cl1on_ack  (cl1on_ack),
    .running    (running),
    .train_sym  (train_sym),
    .cl1on_rqst (cl1on_rqst),
    .rst_ack    (rst_ack)
  );

  word_sender u_sender (
    .clk        (clk),
    .rst_n      (rst_n),
    .running    (running),
    .train_sym  (train_sym),
    .send_tvalid(send_tvalid),
    .send_tdata (send_tdata),
    .send_tuser (send_tuser),
    .send_tready(send_tready),
    .send_tdone (send_tdone),
    .linktx     (linktx)
  );

  word_receiver u_receiver (
    .clk       (clk),
    .rst_n     (rst_n),
    .running   (running),
    .link_sync (link_sync),
    .recv_tdata(recv_tdata),
    .recv_tuser(recv_tuser),
    .recv_tdone(recv_tdone)
  );

endmodule

`default_nettype wire

//--- logic/hl2link_pkg.sv
`default_nettype none

package hl2link_pkg;

  localparam int word_w      = 38;
  localparam int cmd_cycles  = 19;  // 38 bits
  localparam int rxs_cycles  = 12;  // 24 bits
  localparam int txiq_cycles = 16;  // 16 + 16 bits
  localparam int cnt_w       = 5;
  localparam int tick_period = 32;

  // Doubles as the tag symbol on the wire
  typedef enum logic [1:0] {
    kind_none      = 2'd0,
    kind_cmd       = 2'd1,
    kind_rx_sample = 2'd2,
    kind_tx_iq     = 2'd3
  } word_kind_e;

  typedef enum logic [3:0] {
    link_up = 4'b0000,
    link_m0 = 4'b1010,
    link_m1 = 4'b1001,
    link_m2 = 4'b1011,
    link_m3 = 4'b1000,
    link_s0 = 4'b1100,
    link_s1 = 4'b1101,
    link_s2 = 4'b1110,
    link_s3 = 4'b1111
  } link_state_e;

  typedef enum logic [1:0] {
    send_idle,
    send_work,
    send_sync1,
    send_sync2
  } send_state_e;

  typedef enum logic {
    recv_idle,
    recv_work
  } recv_state_e;

  // Payload cycles minus one, the counter start value
  function automatic logic [cnt_w-1:0] kind_last(word_kind_e kind);
    case (kind)
      kind_cmd:       kind_last = cnt_w'(cmd_cycles - 1);
      kind_rx_sample: kind_last = cnt_w'(rxs_cycles - 1);
      kind_tx_iq:     kind_last = cnt_w'(txiq_cycles - 1);
      default:        kind_last = '0;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- logic/link_rx_filter.sv
`timescale 1ns/10ps
`default_nettype none

module link_rx_filter (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic [1:0] linkrx,
  output logic      [1:0] link_sync,
  output logic      [1:0] link_stable
);

  logic [1:0] sync_q1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1     <= 2'b00;
      link_sync   <= 2'b00;
      link_stable <= 2'b00;
    end else begin
      sync_q1   <= linkrx;
      link_sync <= sync_q1;
      // Only take a value seen on two cycles in a row
      if (sync_q1 == link_sync) begin
        link_stable <= link_sync;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/link_trainer.sv
`timescale 1ns/10ps
`default_nettype none

module link_trainer (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       master_sel,
  input  wire logic [1:0] link_stable,
  input  wire logic       cl1on_ack,
  output logic            running,
  output logic      [1:0] train_sym,
  output logic            cl1on_rqst,
  output logic            rst_ack
);

  import hl2link_pkg::*;

  link_state_e      state;
  link_state_e      state_next;
  logic [cnt_w-1:0] tick_cnt;
  logic             tick;
  logic             master_q;
  logic             role_chg;
  logic             zero_seen;
  logic             line_stuck;

  assign tick     = (tick_cnt == cnt_w'(tick_period - 1));
  assign role_chg = (master_sel != master_q);

  // A word never keeps the line nonzero for a whole tick period,
  // so a steady symbol means the peer has gone back to training
  assign line_stuck = tick && !zero_seen && (link_stable != 2'b00);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= link_s0;
      tick_cnt  <= '0;
      master_q  <= 1'b0;
      zero_seen <= 1'b0;
    end else begin
      state    <= state_next;
      tick_cnt <= tick ? '0 : tick_cnt + cnt_w'(1);
      master_q <= master_sel;
      if (tick) begin
        zero_seen <= (link_stable == 2'b00);
      end else if (link_stable == 2'b00) begin
        zero_seen <= 1'b1;
      end
    end
  end

  always_comb begin
    state_next = state;
    if (role_chg) begin
      state_next = master_sel ? link_m0 : link_s0;
    end else begin
      case (state)
        link_m0: if (tick && link_stable == 2'd1) state_next = link_m1;
        link_m1: begin
          case (link_stable)
            2'd1:    if (tick) state_next = link_m0;  // Slave never moved on
            2'd2:    if (tick) state_next = link_m2;
            default: state_next = link_m0;
          endcase
        end
        link_m2: begin
          case (link_stable)
            2'd2:    if (tick) state_next = link_m0;
            2'd3:    if (tick) state_next = link_m3;
            default: state_next = link_m0;
          endcase
        end
        // Slave is finishing its clock handshake
        link_m3: if (link_stable == 2'd0) state_next = link_up;
        link_s0: if (link_stable == 2'd2) state_next = link_s1;
        link_s1: begin
          case (link_stable)
            2'd2:    state_next = link_s1;
            2'd1:    state_next = link_s2;
            default: state_next = link_s0;
          endcase
        end
        link_s2: begin
          case (link_stable)
            2'd1:    state_next = link_s2;
            2'd3:    state_next = link_s3;
            default: state_next = link_s0;
          endcase
        end
        link_s3: begin
          case (link_stable)
            2'd0:    if (cl1on_ack) state_next = link_up;
            2'd3:    state_next = link_s3;
            default: state_next = link_s0;
          endcase
        end
        link_up: if (line_stuck) state_next = master_sel ? link_m0 : link_s0;
        default: state_next = link_s0;
      endcase
    end
  end

  always_comb begin
    case (state)
      link_m0: train_sym = 2'd2;
      link_m1: train_sym = 2'd1;
      link_m2: train_sym = 2'd3;
      link_s1: train_sym = 2'd1;
      link_s2: train_sym = 2'd2;
      link_s3: train_sym = 2'd3;
      default: train_sym = 2'd0;  // m3, s0 and up keep the line quiet
    endcase
  end

  assign running    = (state == link_up);
  assign cl1on_rqst = (state == link_s3);
  assign rst_ack    = (state == link_s0);

endmodule

`default_nettype wire

//--- logic/word_receiver.sv
`timescale 1ns/10ps
`default_nettype none

module word_receiver (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic                           running,
  input  wire logic                     [1:0] link_sync,
  output logic      [hl2link_pkg::word_w-1:0] recv_tdata,
  output hl2link_pkg::word_kind_e             recv_tuser,
  output logic                                recv_tdone
);

  import hl2link_pkg::*;

  recv_state_e      state;
  logic [cnt_w-1:0] cnt;
  logic             tag_seen;

  assign tag_seen = running && (state == recv_idle) && (link_sync != 2'b00);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= recv_idle;
      cnt        <= '0;
      recv_tdone <= 1'b0;
    end else begin
      recv_tdone <= 1'b0;
      if (!running) begin
        state <= recv_idle;
      end else if (tag_seen) begin
        cnt   <= kind_last(word_kind_e'(link_sync));
        state <= recv_work;
      end else if (state == recv_work) begin
        cnt <= cnt - cnt_w'(1);
        if (cnt == '0) begin
          recv_tdone <= 1'b1;  // Last pair lands on this edge
          state      <= recv_idle;
        end
      end
    end
  end

  // Short kinds fill only the low bits
  always_ff @(posedge clk) begin
    if (tag_seen) begin
      recv_tuser <= word_kind_e'(link_sync);
    end
    if (state == recv_work) begin
      recv_tdata <= {recv_tdata[word_w-3:0], link_sync};
    end
  end

endmodule

`default_nettype wire

//--- logic/word_sender.sv
`timescale 1ns/10ps
`default_nettype none

module word_sender (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic                           running,
  input  wire logic                     [1:0] train_sym,
  input  wire logic                           send_tvalid,
  input  wire logic [hl2link_pkg::word_w-1:0] send_tdata,
  input  wire hl2link_pkg::word_kind_e        send_tuser,
  output logic                                send_tready,
  output logic                                send_tdone,
  output logic                          [1:0] linktx
);

  import hl2link_pkg::*;

  send_state_e       state;
  logic [cnt_w-1:0]  cnt;
  logic [word_w-1:0] shreg;
  logic              accept;

  assign send_tready = running && (state == send_idle);
  assign send_tdone  = (state == send_sync2);
  assign accept      = send_tready && send_tvalid && (send_tuser != kind_none);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= send_idle;
      cnt    <= '0;
      linktx <= 2'b00;
    end else if (!running) begin
      state  <= send_idle;
      linktx <= train_sym;
    end else begin
      case (state)
        send_idle: begin
          if (accept) begin
            linktx <= send_tuser;  // Tag goes out first
            cnt    <= kind_last(send_tuser);
            state  <= send_work;
          end else begin
            linktx <= 2'b00;
          end
        end
        send_work: begin
          linktx <= shreg[word_w-1 -: 2];
          cnt    <= cnt - cnt_w'(1);
          if (cnt == '0) begin
            state <= send_sync1;
          end
        end
        // Two quiet cycles so the peer's receiver catches up
        send_sync1: begin
          linktx <= 2'b00;
          state  <= send_sync2;
        end
        send_sync2: begin
          linktx <= 2'b00;
          state  <= send_idle;
        end
        default: state <= send_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      shreg <= send_tdata;
    end else if (state == send_work) begin
      shreg <= {shreg[word_w-3:0], 2'b00};  // MSB pair first
    end
  end

endmodule

`default_nettype wire

//--- verification/hl2link_tb.sv
`timescale 1ns/10ps
`default_nettype none

module hl2link_tb;

  import hl2link_pkg::*;

  localparam int timeout_cycles = 4000;
  localparam int random_words   = 40;

  logic              clk;
  logic              rst_n;
  logic              d_master_sel;
  logic              p_ack;
  logic [1:0]        d_tx;
  logic [1:0]        p_tx;
  logic              d_running, p_running;
  logic              d_rqst, p_rqst;
  logic              d_rst_ack, p_rst_ack;
  logic              d_tvalid, p_tvalid;
  logic              d_tready, p_tready;
  logic              d_tdone, p_tdone;
  logic [word_w-1:0] d_tdata, p_tdata;
  logic [word_w-1:0] d_rdata, p_rdata;
  word_kind_e        d_tuser, p_tuser;
  word_kind_e        d_ruser, p_ruser;
  logic              d_rdone, p_rdone;

  logic [word_w+1:0] to_peer_q[$];  // {kind, data}
  logic [word_w+1:0] to_dut_q[$];
  int                d_busy;  // Cycles left until send_tdone
  int                p_busy;
  int                ack_delay;
  logic              rqst_seen;
  string             test_name;

  hl2link u_dut (
    .clk(clk), .rst_n(rst_n), .linkrx(p_tx), .linktx(d_tx),
    .master_sel(d_master_sel), .cl1on_ack(1'b0), .cl1on_rqst(d_rqst),
    .running(d_running), .rst_ack(d_rst_ack),
    .send_tvalid(d_tvalid), .send_tdata(d_tdata), .send_tuser(d_tuser),
    .send_tready(d_tready), .send_tdone(d_tdone),
    .recv_tdata(d_rdata), .recv_tuser(d_ruser), .recv_tdone(d_rdone)
  );

  hl2link u_peer (
    .clk(clk), .rst_n(rst_n), .linkrx(d_tx), .linktx(p_tx),
    .master_sel(1'b0), .cl1on_ack(p_ack), .cl1on_rqst(p_rqst),
    .running(p_running), .rst_ack(p_rst_ack),
    .send_tvalid(p_tvalid), .send_tdata(p_tdata), .send_tuser(p_tuser),
    .send_tready(p_tready), .send_tdone(p_tdone),
    .recv_tdata(p_rdata), .recv_tuser(p_ruser), .recv_tdone(p_rdone)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic int payload_cycles(word_kind_e kind);
    case (kind)
      kind_cmd:       return cmd_cycles;
      kind_rx_sample: return rxs_cycles;
      kind_tx_iq:     return txiq_cycles;
      default:        return 0;
    endcase
  endfunction

  // Top 2N sent bits end up right aligned
  function automatic logic [word_w-1:0] payload_of(word_kind_e kind, logic [word_w-1:0] data);
    return data >> (word_w - 2 * payload_cycles(kind));
  endfunction

  function automatic logic [word_w-1:0] payload_mask(word_kind_e kind);
    return {word_w{1'b1}} >> (word_w - 2 * payload_cycles(kind));
  endfunction

  task automatic report_error(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string dir, input logic [word_w+1:0] exp,
                            input word_kind_e kind, input logic [word_w-1:0] data);
    word_kind_e        exp_kind;
    logic [word_w-1:0] exp_data;
    exp_kind = word_kind_e'(exp[word_w+1:word_w]);
    exp_data = payload_of(exp_kind, exp[word_w-1:0]);
    assert (kind == exp_kind) else report_error($sformatf(
      "FAILED %s %s kind: expected %0d actual %0d", test_name, dir, exp_kind, kind));
    assert ((data & payload_mask(exp_kind)) == exp_data) else report_error($sformatf(
      "FAILED %s %s data: expected %h actual %h", test_name, dir, exp_data,
      data & payload_mask(exp_kind)));
  endtask

  // Scoreboard
  always @(posedge clk) begin
    if (rst_n) begin
      if (d_tvalid && d_tready && d_tuser != kind_none) begin
        to_peer_q.push_back({d_tuser, d_tdata});
      end
      if (p_tvalid && p_tready && p_tuser != kind_none) begin
        to_dut_q.push_back({p_tuser, p_tdata});
      end
      // Training symbols can look like tags while one side is down
      if (d_running && p_running) begin
        if (p_rdone) begin
          if (to_peer_q.size() == 0) report_error("peer received a word that was never sent");
          else check_word("to peer", to_peer_q.pop_front(), p_ruser, p_rdata);
        end
        if (d_rdone) begin
          if (to_dut_q.size() == 0) report_error("dut received a word that was never sent");
          else check_word("to dut", to_dut_q.pop_front(), d_ruser, d_rdata);
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d_busy    <= 0;
      p_busy    <= 0;
      rqst_seen <= 1'b0;
    end else begin
      if (d_tvalid && d_tready && d_tuser != kind_none) d_busy <= payload_cycles(d_tuser) + 2;
      else if (d_busy != 0) d_busy <= d_busy - 1;
      if (p_tvalid && p_tready && p_tuser != kind_none) p_busy <= payload_cycles(p_tuser) + 2;
      else if (p_busy != 0) p_busy <= p_busy - 1;
      if (p_rst_ack) rqst_seen <= 1'b0;  // Peer back at the start of training
      else if (p_rqst) rqst_seen <= 1'b1;
    end
  end

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !(d_running || p_running ||
      d_tready || p_tready || d_tdone || p_tdone || d_rdone || p_rdone || d_rqst || p_rqst))
    else report_error("outputs were not quiet during reset");
  a_rqst_first: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(p_running) |-> rqst_seen)
    else report_error("peer raised running without raising cl1on_rqst first");
  a_d_busy: assert property (@(posedge clk) disable iff (!rst_n) d_busy != 0 |-> !d_tready)
    else report_error("dut send_tready was high while a word was in flight");
  a_p_busy: assert property (@(posedge clk) disable iff (!rst_n) p_busy != 0 |-> !p_tready)
    else report_error("peer send_tready was high while a word was in flight");
  a_d_done: assert property (@(posedge clk) disable iff (!rst_n) d_tdone == (d_busy == 1))
    else report_error("dut send_tdone did not come N+2 cycles after acceptance");
  a_p_done: assert property (@(posedge clk) disable iff (!rst_n) p_tdone == (p_busy == 1))
    else report_error("peer send_tdone did not come N+2 cycles after acceptance");
  a_d_ready: assert property (@(posedge clk) disable iff (!rst_n)
      (d_busy == 1 && d_running) |=> d_tready)
    else report_error("dut send_tready did not return after send_tdone");
  a_p_ready: assert property (@(posedge clk) disable iff (!rst_n)
      (p_busy == 1 && p_running) |=> p_tready)
    else report_error("peer send_tready did not return after send_tdone");
  a_d_none: assert property (@(posedge clk) disable iff (!rst_n)
      (d_tvalid && d_tready && d_tuser == kind_none) |=> (d_tready && d_busy == 0))
    else report_error("dut accepted a request of kind none");

  // Clock-ready acknowledge for the peer, a few cycles after its request
  initial begin
    p_ack     = 1'b0;
    ack_delay = 0;
    forever begin
      @(posedge clk);
      #1;
      if (!p_rqst) begin
        p_ack     = 1'b0;
        ack_delay = 2 + int'($urandom_range(7));
      end else if (ack_delay != 0) begin
        ack_delay--;
      end else begin
        p_ack = 1'b1;
      end
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_trained();
    int n;
    for (n = 0; n < timeout_cycles; n++) begin
      if (d_running && p_running) return;
      next_cycle();
    end
    report_error("link did not train before the timeout");
  endtask

  task automatic wait_delivered();
    int n;
    for (n = 0; n < timeout_cycles; n++) begin
      if (to_peer_q.size() == 0 && to_dut_q.size() == 0 && d_busy == 0 && p_busy == 0) return;
      next_cycle();
    end
    report_error("sent words were not delivered before the timeout");
  endtask

  task automatic send_word(input bit from_dut, input word_kind_e kind,
                           input logic [word_w-1:0] data);
    int   n;
    logic taken;
    taken = 1'b0;
    if (from_dut) begin
      d_tvalid = 1'b1;
      d_tuser  = kind;
      d_tdata  = data;
    end else begin
      p_tvalid = 1'b1;
      p_tuser  = kind;
      p_tdata  = data;
    end
    for (n = 0; n < timeout_cycles && !taken; n++) begin
      taken = from_dut ? d_tready : p_tready;  // Ready seen by the coming edge
      next_cycle();
    end
    if (from_dut) d_tvalid = 1'b0;
    else p_tvalid = 1'b0;
    if (!taken) report_error("send_tready did not come back before the timeout");
  endtask

  task automatic send_random(input bit from_dut);
    int          i;
    logic [63:0] r;
    word_kind_e  kind;
    for (i = 0; i < random_words; i++) begin
      r    = {$urandom, $urandom};
      kind = word_kind_e'(2'($urandom_range(3, 1)));
      send_word(from_dut, kind, r[word_w-1:0]);
    end
  endtask

  initial begin
    void'($urandom(32'h2370));
    rst_n        = 1'b1;
    d_master_sel = 1'b1;
    d_tvalid     = 1'b0;
    p_tvalid     = 1'b0;
    d_tdata      = '0;
    p_tdata      = '0;
    d_tuser      = kind_none;
    p_tuser      = kind_none;
    test_name    = "reset";
    #1;
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (2) next_cycle();
    assert (!(d_running || p_running || d_tready || p_tready || p_rqst))
      else report_error("outputs were not quiet right after reset");
    assert (p_rst_ack && !d_rst_ack)
      else report_error("rst_ack did not show the slave start state after reset");
    wait_trained();

    test_name = "cmd";
    send_word(1'b1, kind_cmd, 38'h2a_5a5a_c3c3);
    wait_delivered();
    send_word(1'b0, kind_cmd, 38'h15_0f0f_9696);
    wait_delivered();

    test_name = "short";
    send_word(1'b1, kind_rx_sample, 38'h3c_1234_5678);
    wait_delivered();
    send_word(1'b0, kind_tx_iq, 38'h1e_cafe_f00d);
    wait_delivered();

    test_name = "none";
    d_tuser  = kind_none;
    d_tvalid = 1'b1;
    repeat (6) next_cycle();
    d_tvalid = 1'b0;
    wait_delivered();

    test_name = "random";
    fork
      send_random(1'b1);
      send_random(1'b0);
    join
    wait_delivered();

    test_name    = "retrain";
    d_master_sel = 1'b0;
    next_cycle();
    next_cycle();
    assert (!d_running) else report_error("dut kept running after master_sel changed");
    repeat (4) next_cycle();
    d_master_sel = 1'b1;
    wait_trained();
    send_word(1'b1, kind_cmd, 38'h33_8001_7ffe);
    send_word(1'b0, kind_cmd, 38'h0c_7ffe_8001);
    wait_delivered();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
logic/hl2link_pkg.sv
logic/link_rx_filter.sv
logic/link_trainer.sv
logic/word_sender.sv
logic/word_receiver.sv
logic/hl2link.sv
verification/hl2link_tb.sv
